// File: spi_manager.f
rtl/spi_pkg.sv
rtl/spi_register_file.sv
rtl/spi_shift_engine.sv
rtl/spi_manager.sv
test/spi_manager_checker.sv
test/spi_manager_tb.sv

// File: Bender.yml
package:
  name: spi_manager

sources:
  - rtl/spi_pkg.sv
  - rtl/spi_register_file.sv
  - rtl/spi_shift_engine.sv
  - rtl/spi_manager.sv
  - target: test
    files:
      - test/spi_manager_checker.sv
      - test/spi_manager_tb.sv

// File: test/spi_manager_tb.sv
/* Testbench for the SPI manager: clock, reset, transfer table, bus tasks,
   watchdog, DUT and checker instances */

`timescale 1ns/1ns
`default_nettype none

module spi_manager_tb
  import spi_pkg::*;
();

  localparam int divider_width = 4;
  localparam int clock_period  = 100;
  localparam int fixed_rows    = 6;
  localparam int random_rows   = 6;
  localparam int row_count     = fixed_rows + random_rows;
  localparam int max_divider   = 3;
  // All-ones divider as it reads back with only divider_width bits kept
  localparam logic [31:0] divider_limit = 32'hff >> (8 - divider_width);
  // Rows times 16 half periods times 5, plus room for the register tests
  localparam int watchdog_cycles = (row_count + 1) * 16 * 5 * (max_divider + 1) + 500;

  typedef struct packed {
    spi_mode_t  mode;
    logic [7:0] divider;
    logic [7:0] tx_data;
    logic [7:0] reply;
  } transfer_row_t;

  logic          clock;
  logic          reset_n;
  spi_addr_t     rw_address;
  logic          read_request;
  logic          write_request;
  logic [31:0]   write_data;
  logic [3:0]    write_strobe;
  logic [31:0]   read_data;
  logic          read_response;
  logic          write_response;
  logic          sclk;
  logic          mosi;
  logic          miso;
  logic          cs;

  spi_mode_t     mode_expect;
  logic [7:0]    divider_expect;
  logic [7:0]    tx_expect;
  logic [7:0]    reply_expect;
  logic          expect_read;
  logic [31:0]   expected_data;
  logic          transfer_check;
  logic          test_done;
  int            test_number;
  int            checker_errors;
  int            failures;
  logic [31:0]   lcg_state;
  logic [31:0]   value;
  transfer_row_t rows [row_count];

  spi_manager #(
    .divider_width (divider_width)
  ) dut0 (
    .clock          (clock),
    .reset_n        (reset_n),
    .rw_address     (rw_address),
    .read_request   (read_request),
    .write_request  (write_request),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .sclk           (sclk),
    .mosi           (mosi),
    .miso           (miso),
    .cs             (cs)
  );

  spi_manager_checker checker0 (
    .clock          (clock),
    .reset_n        (reset_n),
    .read_request   (read_request),
    .write_request  (write_request),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .sclk           (sclk),
    .mosi           (mosi),
    .cs             (cs),
    .miso           (miso),
    .mode           (mode_expect),
    .divider        (divider_expect),
    .tx_data        (tx_expect),
    .reply          (reply_expect),
    .expect_read    (expect_read),
    .expected_data  (expected_data),
    .transfer_check (transfer_check),
    .test_done      (test_done),
    .test_number    (test_number),
    .errors         (checker_errors)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // --------------------------------------------------------------------------
  // Bus tasks, each called 5 ns after a rising edge
  // --------------------------------------------------------------------------

  task automatic bus_write(input spi_addr_t addr, input logic [31:0] data,
                           input logic [3:0] strobe);
    int waited;
    waited        = 0;
    rw_address    = addr;
    write_data    = data;
    write_strobe  = strobe;
    write_request = 1'b1;
    @(posedge clock);
    #5;
    write_request = 1'b0;
    while (!write_response && waited < 4) begin
      @(posedge clock);
      #5;
      waited++;
    end
    if (!write_response) begin
      $display("No write response from address 0x%0h", addr);
      failures++;
    end
  endtask

  task automatic bus_read(input spi_addr_t addr, input logic [31:0] expected,
                          input logic check, output logic [31:0] data);
    int waited;
    waited        = 0;
    expect_read   = check;
    expected_data = expected;
    rw_address    = addr;
    read_request  = 1'b1;
    @(posedge clock);
    #5;
    read_request = 1'b0;
    while (!read_response && waited < 4) begin
      @(posedge clock);
      #5;
      waited++;
    end
    if (!read_response) begin
      $display("No read response from address 0x%0h", addr);
      failures++;
    end
    data = read_data;
    // Expectation stays put until the checker has seen the response
    @(posedge clock);
    #5;
  endtask

  task automatic wait_idle();
    logic [31:0] status_word;
    int          polls;
    polls       = 0;
    status_word = 32'h1;
    while (status_word[0] && polls < 400) begin
      bus_read(status_addr, 32'h0, 1'b0, status_word);
      polls++;
    end
    if (status_word[0]) begin
      $display("Transfer never left the busy state");
      failures++;
    end
  endtask

  task automatic finish_test(input int number);
    test_number = number;
    test_done   = 1'b1;
    @(posedge clock);
    #5;
    test_done = 1'b0;
  endtask

  // Second byte goes in while the first transfer runs, when asked
  task automatic run_transfer(input transfer_row_t row, input int number,
                              input logic extra_write, input logic [7:0] second_byte);
    logic [31:0] data;
    mode_expect    = row.mode;
    divider_expect = row.divider;
    tx_expect      = row.tx_data;
    reply_expect   = row.reply;
    transfer_check = 1'b1;
    bus_write(mode_addr, 32'(row.mode), 4'hf);
    bus_write(divider_addr, 32'(row.divider), 4'hf);
    bus_write(chip_select_addr, 32'h0, 4'hf);
    bus_write(write_addr, 32'(row.tx_data), 4'hf);
    if (extra_write) begin
      bus_write(write_addr, 32'(second_byte), 4'hf);
      bus_read(write_addr, 32'(row.tx_data), 1'b1, data);
    end
    wait_idle();
    bus_read(read_addr, 32'(row.reply), 1'b1, data);
    bus_write(chip_select_addr, 32'h1, 4'hf);
    finish_test(number);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  initial begin
    reset_n        = 1'b0;
    rw_address     = '0;
    read_request   = 1'b0;
    write_request  = 1'b0;
    write_data     = 32'h0;
    write_strobe   = 4'h0;
    mode_expect    = '0;
    divider_expect = 8'h00;
    tx_expect      = 8'h00;
    reply_expect   = 8'h00;
    expect_read    = 1'b0;
    expected_data  = 32'h0;
    transfer_check = 1'b0;
    test_done      = 1'b0;
    test_number    = 0;
    failures       = 0;
    lcg_state      = 32'd69359;

    // Mode, divider, transmit byte, device reply
    rows[0] = {2'b00, 8'd0, 8'ha5, 8'h3c};
    rows[1] = {2'b01, 8'd1, 8'h5a, 8'hc3};
    rows[2] = {2'b10, 8'd3, 8'h81, 8'h7e};
    rows[3] = {2'b11, 8'd0, 8'hff, 8'h00};
    rows[4] = {2'b00, 8'd3, 8'h00, 8'hff};
    rows[5] = {2'b11, 8'd1, 8'h96, 8'h69};
    for (int i = fixed_rows; i < row_count; i++) begin
      lcg_state       = lcg_next(lcg_state);
      rows[i].mode    = spi_mode_t'(i[1:0]);
      rows[i].divider = (lcg_state[31:24] % 3 == 2) ? 8'd3 : 8'(lcg_state[31:24] % 3);
      rows[i].tx_data = lcg_state[23:16];
      lcg_state       = lcg_next(lcg_state);
      rows[i].reply   = lcg_state[23:16];
    end

    repeat (5) @(posedge clock);
    #5;
    reset_n = 1'b1;

    // Reset values
    bus_read(mode_addr, 32'h0, 1'b1, value);
    bus_read(chip_select_addr, 32'h1, 1'b1, value);
    bus_read(divider_addr, 32'h0, 1'b1, value);
    bus_read(write_addr, 32'h0, 1'b1, value);
    bus_read(read_addr, 32'h0, 1'b1, value);
    bus_read(status_addr, 32'h0, 1'b1, value);
    finish_test(0);

    // Register access, partial strobes and unknown addresses
    mode_expect = 2'b11;
    bus_write(mode_addr, 32'h3, 4'hf);
    bus_read(mode_addr, 32'h3, 1'b1, value);
    bus_write(mode_addr, 32'h1, 4'b1110);
    bus_read(mode_addr, 32'h3, 1'b1, value);
    bus_write(divider_addr, 32'hff, 4'hf);
    bus_read(divider_addr, divider_limit, 1'b1, value);
    bus_write(divider_addr, 32'h5, 4'b0111);
    bus_read(divider_addr, divider_limit, 1'b1, value);
    bus_write(chip_select_addr, 32'h0, 4'hf);
    bus_read(chip_select_addr, 32'h0, 1'b1, value);
    bus_write(chip_select_addr, 32'h1, 4'hf);
    bus_read(chip_select_addr, 32'h1, 1'b1, value);
    bus_read(5'd24, 32'h0, 1'b1, value);
    bus_read(5'd28, 32'h0, 1'b1, value);
    finish_test(1);

    for (int i = 0; i < row_count; i++) begin
      run_transfer(rows[i], i + 2, 1'b0, 8'h00);
    end
    run_transfer(transfer_row_t'({2'b01, 8'd1, 8'hc6, 8'h5b}), row_count + 2, 1'b1, 8'h39);

    @(posedge clock);
    #5;
    $display("%0d tests, %0d checker errors, %0d testbench errors",
             row_count + 3, checker_errors, failures);
    if (checker_errors == 0 && failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clock_period);
    $display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/spi_manager_checker.sv
/* SPI device model with response timing monitor, read data compare,
   sclk half period measurement and per-test reporting */

`timescale 1ns/1ns
`default_nettype none

module spi_manager_checker
  import spi_pkg::*;
(
  input  logic        clock,
  input  logic        reset_n,
  input  logic        read_request,
  input  logic        write_request,
  input  logic [31:0] read_data,
  input  logic        read_response,
  input  logic        write_response,
  input  logic        sclk,
  input  logic        mosi,
  input  logic        cs,
  output logic        miso,

  // Expectations from the testbench
  input  spi_mode_t   mode,
  input  logic [7:0]  divider,
  input  logic [7:0]  tx_data,
  input  logic [7:0]  reply,
  input  logic        expect_read,
  input  logic [31:0] expected_data,
  input  logic        transfer_check,
  input  logic        test_done,
  input  int          test_number,
  output int          errors
);

  logic       read_request_prev;
  logic       write_request_prev;
  logic       sclk_prev;
  logic       cs_prev;
  logic       leading;
  logic       edge_seen;
  logic [7:0] decoded;
  int         shift_index;
  int         sample_count;
  int         edge_count;
  int         cycles;
  int         test_errors;

  initial begin
    miso        = 1'b0;
    errors      = 0;
    test_errors = 0;
  end

  task automatic mismatch(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    $display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h",
             $time, name, expected, actual);
    errors++;
    test_errors++;
  endtask

  // Everything is sampled mid-cycle, away from the DUT's clock edge
  always @(negedge clock) begin
    if (!reset_n) begin
      miso               = 1'b0;
      cs_prev            = 1'b1;
      sclk_prev          = 1'b0;
      read_request_prev  = 1'b0;
      write_request_prev = 1'b0;
    end else begin
      // Every response follows its request by exactly one cycle
      if (read_response !== read_request_prev)
        mismatch("read_response", 32'(read_request_prev), 32'(read_response));
      if (write_response !== write_request_prev)
        mismatch("write_response", 32'(write_request_prev), 32'(write_response));
      if (read_response && expect_read && read_data !== expected_data)
        mismatch("read_data", expected_data, read_data);
      if (!read_response && read_data !== 32'h0)
        mismatch("read_data outside response", 32'h0, read_data);

      // ----------------------------------------------------------------------
      // Device model
      // ----------------------------------------------------------------------
      if (cs_prev && !cs) begin
        // cpha 0 puts the first bit out before any edge
        miso         = mode.cpha ? 1'b0 : reply[7];
        shift_index  = mode.cpha ? 0 : 1;
        decoded      = 8'h00;
        sample_count = 0;
        edge_count   = 0;
        cycles       = 0;
        edge_seen    = 1'b0;
      end else if (!cs) begin
        cycles++;
        if (sclk !== sclk_prev) begin
          leading = (sclk != mode.cpol);
          if (leading ^ mode.cpha) begin
            decoded = {decoded[6:0], mosi};
            sample_count++;
          end else begin
            if (shift_index < 8)
              miso = reply[7 - shift_index];
            shift_index++;
          end
          if (edge_seen && cycles != divider + 1)
            mismatch("sclk half period", 32'(divider) + 1, cycles);
          edge_seen = 1'b1;
          edge_count++;
          cycles = 0;
        end
      end

      if (test_done) begin
        if (sclk !== mode.cpol)
          mismatch("sclk idle level", 32'(mode.cpol), 32'(sclk));
        if (cs !== 1'b1)
          mismatch("cs", 32'h1, 32'(cs));
        if (transfer_check) begin
          if (decoded !== tx_data)
            mismatch("mosi byte", 32'(tx_data), 32'(decoded));
          if (sample_count != 8)
            mismatch("sampling edges", 32'd8, sample_count);
          if (edge_count != 16)
            mismatch("sclk edges", 32'd16, edge_count);
        end
        $display("test %0d %s, %0d errors", test_number,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
        test_errors = 0;
      end

      read_request_prev  = read_request;
      write_request_prev = write_request;
      cs_prev            = cs;
      sclk_prev          = sclk;
    end
  end

endmodule

`default_nettype wire

// File: rtl/spi_manager.sv
/* SPI manager top level joining the register file and the shift engine */

`timescale 1ns/1ns
`default_nettype none

module spi_manager
  import spi_pkg::*;
#(
  parameter int divider_width = 8
) (
  input  logic        clock,
  input  logic        reset_n,

  // Register bus
  input  spi_addr_t   rw_address,
  input  logic        read_request,
  input  logic        write_request,
  input  logic [31:0] write_data,
  input  logic [3:0]  write_strobe,
  output logic [31:0] read_data,
  output logic        read_response,
  output logic        write_response,

  // Serial pins
  output logic        sclk,
  output logic        mosi,
  input  logic        miso,
  output logic        cs
);

  spi_config_t spi_config;
  spi_start_t  start_request;
  spi_status_t status;
  logic        chip_select;

  spi_register_file #(
    .divider_width (divider_width)
  ) register_file0 (
    .clock          (clock),
    .reset_n        (reset_n),
    .rw_address     (rw_address),
    .read_request   (read_request),
    .write_request  (write_request),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .status         (status),
    .spi_config     (spi_config),
    .start_request  (start_request),
    .chip_select    (chip_select)
  );

  spi_shift_engine #(
    .divider_width (divider_width)
  ) shift_engine0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .spi_config    (spi_config),
    .start_request (start_request),
    .status        (status),
    .sclk          (sclk),
    .mosi          (mosi),
    .miso          (miso)
  );

  // Chip select stays under software control
  assign cs = chip_select;

endmodule

`default_nettype wire

// File: rtl/spi_shift_engine.sv
/* SPI shift engine: clock divider, one-hot half-period FSM, MSB-first
   mosi drive and miso sampling into the receive byte */

`timescale 1ns/1ns
`default_nettype none

module spi_shift_engine
  import spi_pkg::*;
#(
  parameter int divider_width = 8
) (
  input  logic        clock,
  input  logic        reset_n,

  // From the register file
  input  spi_config_t spi_config,
  input  spi_start_t  start_request,
  output spi_status_t status,

  // Serial pins
  output logic        sclk,
  output logic        mosi,
  input  logic        miso
);

  // One-hot states, idle plus one per sclk level
  typedef enum logic [2:0] {
    state_idle     = 3'b001,
    state_polarity = 3'b010,
    state_inverted = 3'b100
  } engine_state_t;

  engine_state_t            state;
  spi_mode_t                mode_q;
  logic [divider_width-1:0] divider_q;
  logic [divider_width-1:0] cycle_count;
  logic [3:0]               half_count;
  logic [3:0]               next_half;
  logic [7:0]               tx_q;
  logic [7:0]               rx_q;
  logic                     sclk_prev;
  logic                     half_end;
  logic                     last_half;
  logic                     sample_edge;

  assign half_end  = (cycle_count == divider_q);
  assign last_half = (half_count == 4'd15);
  assign next_half = half_count + 4'd1;

  // --------------------------------------------------------------------------
  // Transfer payload
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (state == state_idle && start_request.start) begin
      tx_q      <= start_request.tx_data;
      divider_q <= spi_config.divider[divider_width-1:0];
    end
  end

  // --------------------------------------------------------------------------
  // Half-period state machine
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state       <= state_idle;
      mode_q      <= '0;
      sclk        <= 1'b0;
      mosi        <= 1'b0;
      cycle_count <= '0;
      half_count  <= 4'd0;
    end else begin
      case (state)
        state_idle: begin
          // Mode tracks the register so sclk settles before cs falls
          mode_q      <= spi_config.mode;
          sclk        <= spi_config.mode.cpol;
          mosi        <= 1'b0;
          cycle_count <= '0;
          half_count  <= 4'd0;
          if (start_request.start) begin
            // First bit is out before any edge
            mosi <= start_request.tx_data[7];
            if (spi_config.mode.cpha) begin
              // Leading edge comes right away and shifts
              state <= state_inverted;
              sclk  <= ~spi_config.mode.cpol;
            end else begin
              state <= state_polarity;
            end
          end
        end

        state_polarity, state_inverted: begin
          if (half_end) begin
            cycle_count <= '0;
            if (last_half) begin
              state <= state_idle;
              sclk  <= mode_q.cpol;
              mosi  <= 1'b0;
            end else begin
              half_count <= next_half;
              // Each bit spans two half periods, MSB first
              mosi       <= tx_q[~next_half[3:1]];
              if (state == state_polarity) begin
                state <= state_inverted;
                sclk  <= ~mode_q.cpol;
              end else begin
                state <= state_polarity;
                sclk  <= mode_q.cpol;
              end
            end
          end else begin
            cycle_count <= cycle_count + 1'b1;
          end
        end

        default: begin
          state <= state_idle;
          sclk  <= mode_q.cpol;
          mosi  <= 1'b0;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Receive shifter
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      sclk_prev <= 1'b0;
    end else begin
      sclk_prev <= sclk;
    end
  end

  // Falling edge when cpol xor cpha, rising edge otherwise
  assign sample_edge = (mode_q.cpol ^ mode_q.cpha) ? (sclk_prev && !sclk)
                                                   : (!sclk_prev && sclk);

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      rx_q <= 8'h00;
    end else if (sample_edge && state != state_idle) begin
      rx_q <= {rx_q[6:0], miso};
    end
  end

  assign status = '{busy: (state != state_idle), rx_data: rx_q};

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  state_onehot : assert property (
    @(posedge clock) disable iff (!reset_n)
    $onehot(state)
  );

  // No stray clock edges outside a transfer
  idle_sclk_level : assert property (
    @(posedge clock) disable iff (!reset_n)
    !status.busy |-> (sclk == mode_q.cpol)
  );

endmodule

`default_nettype wire

// File: rtl/spi_register_file.sv
/* SPI register file: bus write decode, mode, chip select, divider and
   transmit registers, registered read mux, responses and transfer start */

`timescale 1ns/1ns
`default_nettype none

module spi_register_file
  import spi_pkg::*;
#(
  parameter int divider_width = 8
) (
  input  logic        clock,
  input  logic        reset_n,

  // Register bus
  input  spi_addr_t   rw_address,
  input  logic        read_request,
  input  logic        write_request,
  input  logic [31:0] write_data,
  input  logic [3:0]  write_strobe,
  output logic [31:0] read_data,
  output logic        read_response,
  output logic        write_response,

  // Shift engine side
  input  spi_status_t status,
  output spi_config_t spi_config,
  output spi_start_t  start_request,
  output logic        chip_select
);

  // Only the low divider_width bits of the divider are kept
  localparam logic [7:0] divider_mask = 8'((16'd1 << divider_width) - 16'd1);

  spi_mode_t   mode_q;
  logic [7:0]  divider_q;
  logic [7:0]  tx_q;
  logic        write_valid;
  logic        tx_write;
  logic [31:0] read_mux;

  // Partial writes are ignored entirely
  assign write_valid = write_request && (&write_strobe);
  assign tx_write    = write_valid && (rw_address == write_addr);

  // --------------------------------------------------------------------------
  // Control registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mode_q      <= '0;
      chip_select <= 1'b1;
      divider_q   <= 8'h00;
      tx_q        <= 8'h00;
    end else if (write_valid) begin
      case (rw_address)
        mode_addr: begin
          mode_q <= spi_mode_t'(write_data[1:0]);
        end
        chip_select_addr: begin
          chip_select <= write_data[0];
        end
        divider_addr: begin
          divider_q <= write_data[7:0] & divider_mask;
        end
        write_addr: begin
          // A byte written mid-transfer is acknowledged and dropped
          if (!status.busy) begin
            tx_q <= write_data[7:0];
          end
        end
        default: begin
        end
      endcase
    end
  end

  assign spi_config = '{mode: mode_q, divider: divider_q};

  // --------------------------------------------------------------------------
  // Transfer start
  // --------------------------------------------------------------------------

  // Engine latches the byte on this pulse and raises busy next cycle
  assign start_request = '{
    start:   tx_write && !status.busy,
    tx_data: write_data[7:0]
  };

  // --------------------------------------------------------------------------
  // Read mux and responses
  // --------------------------------------------------------------------------

  always_comb begin
    case (rw_address)
      mode_addr:        read_mux = 32'(mode_q);
      chip_select_addr: read_mux = 32'(chip_select);
      divider_addr:     read_mux = 32'(divider_q);
      write_addr:       read_mux = 32'(tx_q);
      read_addr:        read_mux = 32'(status.rx_data);
      status_addr:      read_mux = 32'(status.busy);
      default:          read_mux = 32'h0000_0000;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_data      <= 32'h0000_0000;
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
      // Data bus is zero outside a read response
      read_data      <= read_request ? read_mux : 32'h0000_0000;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // A start is followed by busy on the next cycle
  start_raises_busy : assert property (
    @(posedge clock) disable iff (!reset_n)
    start_request.start |=> status.busy
  );

endmodule

`default_nettype wire

// File: rtl/spi_pkg.sv
/* Register map, mode and configuration structs, and the start and status
   records passed between the SPI register file and the shift engine */

`default_nettype none

package spi_pkg;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------

  typedef logic [4:0] spi_addr_t;

  localparam spi_addr_t mode_addr        = 5'd0;
  localparam spi_addr_t chip_select_addr = 5'd4;
  localparam spi_addr_t divider_addr     = 5'd8;
  localparam spi_addr_t write_addr       = 5'd12;
  localparam spi_addr_t read_addr        = 5'd16;
  localparam spi_addr_t status_addr      = 5'd20;

  // Width of the divider field as seen on the bus
  localparam int divider_default_width = 8;

  // --------------------------------------------------------------------------
  // Configuration and handshake records
  // --------------------------------------------------------------------------

  // Bit 1 is cpol, bit 0 is cpha, as in the mode register
  typedef struct packed {
    logic cpol;
    logic cpha;
  } spi_mode_t;

  typedef struct packed {
    spi_mode_t                          mode;
    logic [divider_default_width-1:0]   divider;
  } spi_config_t;

  // Engine state reported back to the register file
  typedef struct packed {
    logic       busy;
    logic [7:0] rx_data;
  } spi_status_t;

  // One-cycle start pulse with the byte to send
  typedef struct packed {
    logic       start;
    logic [7:0] tx_data;
  } spi_start_t;

endpackage

`default_nettype wire
